/* filelist.f */
verilog/cpu_pkg.sv
verilog/register_file.sv
verilog/alu.sv
verilog/decode_unit.sv
verilog/hazard_unit.sv
verilog/forwarding_unit.sv
verilog/cpu_core.sv
test/cpu_core_tb.sv

/* test/cpu_core_tb.sv */
`timescale 1ns/10ps

module cpu_core_tb;

  localparam int clk_period = 40;
  localparam int reset_cycles = 4;
  localparam int mem_words = 256;
  localparam int hold_cycles = 8;
  localparam string pattern_file = "test/program_patterns.txt";

  logic                           clk;
  logic                           arst_n;
  logic [cpu_pkg::data_width-1:0] inst;
  logic [cpu_pkg::data_width-1:0] dmem_rdata;
  logic [cpu_pkg::data_width-1:0] pc;
  logic [cpu_pkg::data_width-1:0] dmem_addr;
  logic [cpu_pkg::data_width-1:0] dmem_wdata;
  logic                           dmem_we;
  logic                           hlt;

  // Word-indexed memories, byte address bits 8:1
  logic [cpu_pkg::data_width-1:0] imem [mem_words];
  logic [cpu_pkg::data_width-1:0] dmem [mem_words];

  // Expected stores in program order
  logic [cpu_pkg::data_width-1:0] exp_addr [$];
  logic [cpu_pkg::data_width-1:0] exp_data [$];
  logic [cpu_pkg::data_width-1:0] halt_pc;

  int prog_words;
  int store_count;
  int store_errors;
  int halt_errors;
  int load_errors;
  bit loaded;

  cpu_core UUT (
    .clk(clk), .arst_n(arst_n), .inst(inst), .dmem_rdata(dmem_rdata),
    .pc(pc), .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
    .dmem_we(dmem_we), .hlt(hlt)
  );

  always #(clk_period / 2) clk = ~clk;

  // Unwritten program space decodes as HLT
  task automatic fill_memories();
    for (int i = 0; i < mem_words; i++) begin
      imem[i] = 16'hf000 | 16'(i);
      dmem[i] = {8'(i), ~8'(i)};
    end
  endtask

  // Tag letter, then hex fields; '#' starts a comment to end of line
  task automatic load_patterns();
    int fd;
    int c;
    int n;
    logic [cpu_pkg::data_width-1:0] a;
    logic [cpu_pkg::data_width-1:0] d;
    fd = $fopen(pattern_file, "r");
    if (fd == 0) begin
      $display("Cannot open pattern file %s", pattern_file);
      load_errors++;
    end else begin
      c = $fgetc(fd);
      while (c != -1) begin
        if (c == "#") begin
          while ((c != "\n") && (c != -1)) begin
            c = $fgetc(fd);
          end
        end else if (c == "I") begin
          // Four program words per line
          repeat (4) begin
            n = $fscanf(fd, "%h", d);
            if (n != 1) begin
              $display("Program line in pattern file is short after word %0d", prog_words);
              load_errors++;
            end
            imem[prog_words] = d;
            prog_words++;
          end
        end else if (c == "D") begin
          n = $fscanf(fd, "%h %h", a, d);
          if (n != 2) begin
            $display("Data line in pattern file lacks address or word");
            load_errors++;
          end else begin
            dmem[a[8:1]] = d;
          end
        end else if (c == "S") begin
          n = $fscanf(fd, "%h %h", a, d);
          if (n != 2) begin
            $display("Store line in pattern file lacks address or data");
            load_errors++;
          end else begin
            exp_addr.push_back(a);
            exp_data.push_back(d);
          end
        end else if (c == "P") begin
          n = $fscanf(fd, "%h", a);
          if (n != 1) begin
            $display("Halt line in pattern file lacks the pc");
            load_errors++;
          end else begin
            halt_pc = a;
          end
        end
        c = $fgetc(fd);
      end
      $fclose(fd);
    end
  endtask

  // One store pulse against the next expected entry
  task automatic check_store();
    assert (hlt == 1'b0) else begin
      $display("Store to %h at %0t issued after hlt went high", dmem_addr, $time);
      halt_errors++;
    end
    assert (store_count < exp_addr.size()) else begin
      $display("Extra store at %0t to %h after all expected stores", $time, dmem_addr);
      store_errors++;
    end
    if (store_count < exp_addr.size()) begin
      assert (dmem_addr == exp_addr[store_count]) else begin
        $display("[FAIL] %0t dmem_addr expected %h got %h",
                 $time, exp_addr[store_count], dmem_addr);
        store_errors++;
      end
      assert (dmem_wdata == exp_data[store_count]) else begin
        $display("[FAIL] %0t dmem_wdata expected %h got %h",
                 $time, exp_data[store_count], dmem_wdata);
        store_errors++;
      end
    end
    store_count++;
  endtask

  // Memories answer from the falling edge on
  always @(negedge clk) begin
    inst       <= imem[pc[8:1]];
    dmem_rdata <= dmem[dmem_addr[8:1]];
  end

  always @(posedge clk) begin
    if (dmem_we === 1'b1) begin
      dmem[dmem_addr[8:1]] <= dmem_wdata;
    end
  end

  // Store outputs are stable mid-cycle
  always @(negedge clk) begin
    if (dmem_we === 1'b1) begin
      check_store();
    end
  end

  // Bound of 8 cycles per program word plus slack
  initial begin
    wait (loaded);
    #((prog_words * 8 + 100 + reset_cycles) * clk_period);
    $display("Watchdog expired at %0t before the core halted", $time);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    clk          = 1'b0;
    arst_n       = 1'b0;
    inst         = '0;
    dmem_rdata   = '0;
    halt_pc      = '0;
    prog_words   = 0;
    store_count  = 0;
    store_errors = 0;
    halt_errors  = 0;
    load_errors  = 0;
    fill_memories();
    load_patterns();
    loaded = 1'b1;

    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    @(negedge clk);
    assert (hlt == 1'b0) else begin
      $display("[FAIL] %0t hlt expected 0 got %b", $time, hlt);
      halt_errors++;
    end

    // Watchdog ends a run that never halts
    while (hlt !== 1'b1) begin
      @(negedge clk);
    end
    assert (pc == halt_pc) else begin
      $display("[FAIL] %0t pc expected %h got %h", $time, halt_pc, pc);
      halt_errors++;
    end

    // Level must hold, store monitor keeps watching
    repeat (hold_cycles) begin
      @(negedge clk);
      assert (hlt == 1'b1) else begin
        $display("[FAIL] %0t hlt expected 1 got %b", $time, hlt);
        halt_errors++;
      end
    end

    assert (store_count == exp_addr.size()) else begin
      $display("Saw %0d stores but expected %0d", store_count, exp_addr.size());
      store_errors++;
    end

    $display("Error counts: store %0d, halt %0d, load %0d",
             store_errors, halt_errors, load_errors);
    if ((store_errors + halt_errors + load_errors) == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* test/program_patterns.txt */
# Tag I has four program words | D data address and word | S store address and data | P halt pc
# All values hex, I words in fetch order from address 0, S entries in store order
D 0090 7000
D 0092 8001
I a180 a290 8320 0433   # llb r1, llb r2, lw r3, add r4 saturates after load-use
I 9410 8521 1654 9611   # sw r4, lw r5, sub r6 saturates negative, sw r6
I 2746 9712 4854 5953   # xor r7, sw r7, sll r8, sra r9
I 6a54 9813 9914 9a15   # ror r10, stores of r8 r9 r10
I 0b88 0bb8 1cbb 9b16   # dependent adds into r11, sub r12 sets Z, sw r11
I c201 9717 c001 9c17   # beq taken over marker, bne not taken, sw r12
I 1d94 c602 f000 9d1f   # sub r13 saturates, blt right after it, hlt in flushed slot
I 9d1e c401 cc01 9717   # sw r13, bgt not taken, bov taken over marker
I c801 9a17 ca01 9717   # bge not taken, sw r10, ble taken over marker
I c201 c001 9717 0e80   # beq not taken, bne taken over marker, add r14 clears V and N
I c601 c401 9717 cc01   # blt not taken, bgt taken over marker, bov not taken
I ca01 c801 9717 9e1d   # ble not taken, bge taken over marker, sw r14
I ef00 9f1c a26e de20   # pcs r15, sw r15, llb r2, br always through r2
I 9717 9717 f000 b212   # flushed and skipped markers, skipped hlt, lhb r2
I 921b ce01 9717 f000   # sw r2, b always over marker, hlt
S 0080 7fff
S 0082 8000
S 0084 ffff
S 0086 0010
S 0088 f000
S 008a 1800
S 008c 0030
S 008e 0000
S 007c 8000
S 008e 1800
S 007a 0010
S 0078 0062
S 0076 126e
P 0076

/* verilog/alu.sv */
`timescale 1ns/10ps

module alu (
  input  cpu_pkg::opcode_t               opcode,
  input  logic [cpu_pkg::data_width-1:0] in_a,
  input  logic [cpu_pkg::data_width-1:0] in_b,
  input  logic [3:0]                     shamt,
  output logic [cpu_pkg::data_width-1:0] result,
  output logic                           zero,
  output logic                           overflow,
  output logic                           negative
);

  logic [cpu_pkg::data_width-1:0]   sum;
  logic [cpu_pkg::data_width-1:0]   diff;
  logic [2*cpu_pkg::data_width-1:0] rot;
  logic                             sum_ovf;
  logic                             diff_ovf;
  logic [cpu_pkg::data_width-1:0]   sat_val;

  // One adder, one subtractor
  assign sum  = in_a + in_b;
  assign diff = in_a - in_b;

  // Signed overflow
  // Add: same input signs, result sign differs
  assign sum_ovf  = (in_a[15] == in_b[15]) && (sum[15] != in_a[15]);
  // Sub: input signs differ, result sign differs from a
  assign diff_ovf = (in_a[15] != in_b[15]) && (diff[15] != in_a[15]);

  // Clamp toward the sign of in_a
  assign sat_val = in_a[15] ? 16'h8000 : 16'h7fff;

  // Rotate right via doubled word
  assign rot = {in_a, in_a} >> shamt;

  always_comb begin
    result   = '0;
    overflow = 1'b0;
    case (opcode)
      cpu_pkg::op_add: begin
        overflow = sum_ovf;
        result   = sum_ovf ? sat_val : sum;
      end
      cpu_pkg::op_sub: begin
        overflow = diff_ovf;
        result   = diff_ovf ? sat_val : diff;
      end
      // Address add, no clamp
      cpu_pkg::op_lw, cpu_pkg::op_sw: result = sum;
      cpu_pkg::op_xor: result = in_a ^ in_b;
      cpu_pkg::op_sll: result = in_a << shamt;
      cpu_pkg::op_sra: result = $signed(in_a) >>> shamt;
      cpu_pkg::op_ror: result = rot[cpu_pkg::data_width-1:0];
      default: result = '0;
    endcase
  end

  // Z and N from the final result
  assign zero     = (result == '0);
  assign negative = result[15];

endmodule

/* verilog/cpu_core.sv */
`timescale 1ns/10ps

module cpu_core (
  input  logic                           clk,
  input  logic                           arst_n,
  input  logic [cpu_pkg::data_width-1:0] inst,
  input  logic [cpu_pkg::data_width-1:0] dmem_rdata,
  output logic [cpu_pkg::data_width-1:0] pc,
  output logic [cpu_pkg::data_width-1:0] dmem_addr,
  output logic [cpu_pkg::data_width-1:0] dmem_wdata,
  output logic                           dmem_we,
  output logic                           hlt
);

  // Fetch
  logic [cpu_pkg::data_width-1:0]     next_pc;
  logic                               fetch_hlt;
  logic                               stall;
  logic                               flush;
  // IF/ID and decode
  logic [cpu_pkg::data_width-1:0]     id_instr;
  logic [cpu_pkg::data_width-1:0]     id_next_pc;
  cpu_pkg::opcode_t                   id_opcode;
  logic [cpu_pkg::reg_addr_width-1:0] id_rs;
  logic [cpu_pkg::reg_addr_width-1:0] id_src2;
  logic [cpu_pkg::reg_addr_width-1:0] id_rd;
  logic [cpu_pkg::data_width-1:0]     id_rs_val;
  logic [cpu_pkg::data_width-1:0]     id_src2_val;
  logic [cpu_pkg::data_width-1:0]     id_imm;
  logic                               id_reg_write;
  logic                               id_load;
  logic                               id_store;
  logic                               id_flag_write;
  logic                               id_hlt;
  logic                               branch_taken;
  logic [cpu_pkg::data_width-1:0]     branch_target;
  logic [2:0]                         flags;
  // ID/EX and execute
  logic                               ex_reg_write;
  logic                               ex_load;
  logic                               ex_store;
  logic                               ex_flag_write;
  logic                               ex_hlt;
  cpu_pkg::opcode_t                   ex_opcode;
  logic [cpu_pkg::reg_addr_width-1:0] ex_rs;
  logic [cpu_pkg::reg_addr_width-1:0] ex_src2;
  logic [cpu_pkg::reg_addr_width-1:0] ex_rd;
  logic [cpu_pkg::data_width-1:0]     ex_rs_val;
  logic [cpu_pkg::data_width-1:0]     ex_src2_val;
  logic [cpu_pkg::data_width-1:0]     ex_imm;
  logic [3:0]                         ex_shamt;
  logic [cpu_pkg::data_width-1:0]     ex_next_pc;
  cpu_pkg::fwd_sel_t                  fwd_a;
  cpu_pkg::fwd_sel_t                  fwd_b;
  logic [cpu_pkg::data_width-1:0]     ex_a_val;
  logic [cpu_pkg::data_width-1:0]     ex_b_val;
  logic                               ex_mem_op;
  logic [cpu_pkg::data_width-1:0]     alu_a;
  logic [cpu_pkg::data_width-1:0]     alu_b;
  logic [cpu_pkg::data_width-1:0]     alu_result;
  logic                               alu_zero;
  logic                               alu_overflow;
  logic                               alu_negative;
  logic [cpu_pkg::data_width-1:0]     ex_merge;
  logic [cpu_pkg::data_width-1:0]     ex_result;
  // EX/MEM
  logic                               mem_reg_write;
  logic                               mem_load;
  logic                               mem_store;
  logic                               mem_hlt;
  logic [cpu_pkg::reg_addr_width-1:0] mem_rd;
  logic [cpu_pkg::reg_addr_width-1:0] mem_src2;
  logic [cpu_pkg::data_width-1:0]     mem_result;
  logic [cpu_pkg::data_width-1:0]     mem_store_data;
  logic                               fwd_store;
  // MEM/WB
  logic                               wb_reg_write;
  logic                               wb_load;
  logic                               wb_hlt;
  logic [cpu_pkg::reg_addr_width-1:0] wb_rd;
  logic [cpu_pkg::data_width-1:0]     wb_result;
  logic [cpu_pkg::data_width-1:0]     wb_rdata;
  logic [cpu_pkg::data_width-1:0]     wb_data;

  // Fetch stage
  assign next_pc   = pc + cpu_pkg::data_width'(2);
  assign fetch_hlt = (inst[15:12] == cpu_pkg::op_hlt);

  // Taken branch overrides a HLT in fetch
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= cpu_pkg::reset_pc;
    end else if (flush) begin
      pc <= branch_target;
    end else if (!stall && !fetch_hlt) begin
      pc <= next_pc;
    end
  end

  // IF/ID word drives decode controls, so it resets to a no-op
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      id_instr <= cpu_pkg::nop_instr;
    end else if (flush) begin
      id_instr <= cpu_pkg::nop_instr;
    end else if (!stall) begin
      id_instr <= inst;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      id_next_pc <= next_pc;
    end
  end

  // Decode stage
  assign id_rs  = id_instr[7:4];
  assign id_hlt = (id_opcode == cpu_pkg::op_hlt);

  register_file regfile (
    .clk(clk), .arst_n(arst_n),
    .rs_addr(id_rs), .rt_addr(id_src2),
    .wr_addr(wb_rd), .wr_en(wb_reg_write), .wr_data(wb_data),
    .rs_data(id_rs_val), .rt_data(id_src2_val)
  );

  decode_unit decode (
    .instr(id_instr), .next_pc(id_next_pc), .rs_value(id_rs_val), .flags(flags),
    .opcode(id_opcode), .src2_addr(id_src2), .dst_addr(id_rd), .imm_ext(id_imm),
    .reg_write(id_reg_write), .mem_read(id_load), .mem_write(id_store),
    .flag_write(id_flag_write), .branch_taken(branch_taken),
    .branch_target(branch_target)
  );

  hazard_unit hdu (
    .id_opcode(id_opcode), .id_rs(id_rs), .id_src2(id_src2),
    .ex_mem_read(ex_load), .ex_flag_write(ex_flag_write),
    .ex_reg_write(ex_reg_write), .ex_rd(ex_rd),
    .mem_reg_write(mem_reg_write), .mem_rd(mem_rd),
    .branch_taken(branch_taken), .stall(stall), .flush(flush)
  );

  // ID/EX controls, bubble on stall
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      {ex_reg_write, ex_load, ex_store, ex_flag_write, ex_hlt} <= '0;
    end else if (stall) begin
      {ex_reg_write, ex_load, ex_store, ex_flag_write, ex_hlt} <= '0;
    end else begin
      {ex_reg_write, ex_load, ex_store, ex_flag_write, ex_hlt} <=
        {id_reg_write, id_load, id_store, id_flag_write, id_hlt};
    end
  end

  always_ff @(posedge clk) begin
    ex_opcode   <= id_opcode;
    ex_rs       <= id_rs;
    ex_src2     <= id_src2;
    ex_rd       <= id_rd;
    ex_rs_val   <= id_rs_val;
    ex_src2_val <= id_src2_val;
    ex_imm      <= id_imm;
    ex_shamt    <= id_instr[3:0];
    ex_next_pc  <= id_next_pc;
  end

  // Execute stage
  forwarding_unit forward (
    .ex_rs(ex_rs), .ex_src2(ex_src2),
    .mem_rd(mem_rd), .mem_reg_write(mem_reg_write),
    .wb_rd(wb_rd), .wb_reg_write(wb_reg_write),
    .mem_store_src(mem_src2),
    .fwd_a(fwd_a), .fwd_b(fwd_b), .fwd_store(fwd_store)
  );

  assign ex_a_val = (fwd_a == cpu_pkg::fwd_ex_mem) ? mem_result :
                    (fwd_a == cpu_pkg::fwd_mem_wb) ? wb_data : ex_rs_val;
  assign ex_b_val = (fwd_b == cpu_pkg::fwd_ex_mem) ? mem_result :
                    (fwd_b == cpu_pkg::fwd_mem_wb) ? wb_data : ex_src2_val;

  // LW/SW address, halfword aligned base plus offset
  assign ex_mem_op = (ex_opcode == cpu_pkg::op_lw) || (ex_opcode == cpu_pkg::op_sw);
  assign alu_a     = ex_mem_op ? {ex_a_val[15:1], 1'b0} : ex_a_val;
  assign alu_b     = ex_mem_op ? ex_imm : ex_b_val;

  alu alu_ex (
    .opcode(ex_opcode), .in_a(alu_a), .in_b(alu_b), .shamt(ex_shamt),
    .result(alu_result), .zero(alu_zero), .overflow(alu_overflow),
    .negative(alu_negative)
  );

  // Byte merge into old Rd
  assign ex_merge = (ex_opcode == cpu_pkg::op_lhb) ? {ex_imm[15:8], ex_b_val[7:0]} :
                                                     {ex_b_val[15:8], ex_imm[7:0]};

  always_comb begin
    case (ex_opcode)
      cpu_pkg::op_pcs:                 ex_result = ex_next_pc;
      cpu_pkg::op_llb, cpu_pkg::op_lhb: ex_result = ex_merge;
      default:                         ex_result = alu_result;
    endcase
  end

  // Z from every setter
  // V and N only from ADD/SUB
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      flags <= '0;
    end else if (ex_flag_write) begin
      flags[2] <= alu_zero;
      if ((ex_opcode == cpu_pkg::op_add) || (ex_opcode == cpu_pkg::op_sub)) begin
        flags[1:0] <= {alu_overflow, alu_negative};
      end
    end
  end

  // EX/MEM
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      {mem_reg_write, mem_load, mem_store, mem_hlt} <= '0;
    end else begin
      {mem_reg_write, mem_load, mem_store, mem_hlt} <=
        {ex_reg_write, ex_load, ex_store, ex_hlt};
    end
  end

  always_ff @(posedge clk) begin
    mem_rd         <= ex_rd;
    mem_src2       <= ex_src2;
    mem_result     <= ex_result;
    mem_store_data <= ex_b_val;
  end

  // Memory stage ports
  assign dmem_addr  = mem_result;
  assign dmem_we    = mem_store;
  assign dmem_wdata = fwd_store ? wb_data : mem_store_data;

  // MEM/WB
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      {wb_reg_write, wb_load, wb_hlt} <= '0;
    end else begin
      {wb_reg_write, wb_load, wb_hlt} <= {mem_reg_write, mem_load, mem_hlt};
    end
  end

  always_ff @(posedge clk) begin
    wb_rd     <= mem_rd;
    wb_result <= mem_result;
    wb_rdata  <= dmem_rdata;
  end

  // Writeback select
  assign wb_data = wb_load ? wb_rdata : wb_result;

  // Pc frozen on HLT keeps refilling the pipe, so this holds
  assign hlt = wb_hlt;

  no_load_store_overlap: assert property (@(posedge clk) disable iff (!arst_n)
    !(dmem_we && mem_load))
    else $error("load and store together in memory stage");

endmodule

/* verilog/cpu_pkg.sv */
package cpu_pkg;

  // Word size for data, instructions and pc
  localparam int data_width = 16;
  localparam int reg_addr_width = 4;
  localparam int num_regs = 16;

  // First fetch address
  localparam logic [data_width-1:0] reset_pc = '0;

  // Dropped RED opcode, decodes as a no-op
  // Loaded into IF/ID on reset and on a flush
  localparam logic [data_width-1:0] nop_instr = 16'h3000;

  // Opcodes in bits 15:12
  // 0011 and 0111 are unused and run as no-ops
  typedef enum logic [3:0] {
    op_add = 4'b0000,
    op_sub = 4'b0001,
    op_xor = 4'b0010,
    op_sll = 4'b0100,
    op_sra = 4'b0101,
    op_ror = 4'b0110,
    op_lw  = 4'b1000,
    op_sw  = 4'b1001,
    op_llb = 4'b1010,
    op_lhb = 4'b1011,
    op_b   = 4'b1100,
    op_br  = 4'b1101,
    op_pcs = 4'b1110,
    op_hlt = 4'b1111
  } opcode_t;

  // Branch conditions in bits 11:9
  typedef enum logic [2:0] {
    cond_ne = 3'b000,
    cond_eq = 3'b001,
    cond_gt = 3'b010,
    cond_lt = 3'b011,
    cond_ge = 3'b100,
    cond_le = 3'b101,
    cond_ov = 3'b110,
    cond_al = 3'b111
  } br_cond_t;

  // Execute operand source
  typedef enum logic [1:0] {
    fwd_none   = 2'b00,
    fwd_ex_mem = 2'b01,
    fwd_mem_wb = 2'b10
  } fwd_sel_t;

endpackage

/* verilog/decode_unit.sv */
`timescale 1ns/10ps

module decode_unit (
  input  logic [cpu_pkg::data_width-1:0]     instr,
  input  logic [cpu_pkg::data_width-1:0]     next_pc,
  input  logic [cpu_pkg::data_width-1:0]     rs_value,
  input  logic [2:0]                         flags,
  output cpu_pkg::opcode_t                   opcode,
  output logic [cpu_pkg::reg_addr_width-1:0] src2_addr,
  output logic [cpu_pkg::reg_addr_width-1:0] dst_addr,
  output logic [cpu_pkg::data_width-1:0]     imm_ext,
  output logic                               reg_write,
  output logic                               mem_read,
  output logic                               mem_write,
  output logic                               flag_write,
  output logic                               branch_taken,
  output logic [cpu_pkg::data_width-1:0]     branch_target
);

  cpu_pkg::br_cond_t              cond;
  logic                           flag_z;
  logic                           flag_v;
  logic                           flag_n;
  logic                           cond_met;
  logic [cpu_pkg::data_width-1:0] br_offset;

  assign opcode   = cpu_pkg::opcode_t'(instr[15:12]);
  assign cond     = cpu_pkg::br_cond_t'(instr[11:9]);
  assign dst_addr = instr[11:8];
  // Flag order Z, V, N
  assign {flag_z, flag_v, flag_n} = flags;

  always_comb begin
    // Default is Rt source, nothing written
    src2_addr  = instr[3:0];
    imm_ext    = '0;
    reg_write  = 1'b0;
    mem_read   = 1'b0;
    mem_write  = 1'b0;
    flag_write = 1'b0;
    case (opcode)
      cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_xor,
      cpu_pkg::op_sll, cpu_pkg::op_sra, cpu_pkg::op_ror: begin
        reg_write  = 1'b1;
        flag_write = 1'b1;
      end
      cpu_pkg::op_lw: begin
        src2_addr = instr[11:8];
        imm_ext   = {{11{instr[3]}}, instr[3:0], 1'b0};
        reg_write = 1'b1;
        mem_read  = 1'b1;
      end
      // Rd is store data
      cpu_pkg::op_sw: begin
        src2_addr = instr[11:8];
        imm_ext   = {{11{instr[3]}}, instr[3:0], 1'b0};
        mem_write = 1'b1;
      end
      // Old Rd merged with byte in place
      cpu_pkg::op_llb: begin
        src2_addr = instr[11:8];
        imm_ext   = {8'h00, instr[7:0]};
        reg_write = 1'b1;
      end
      cpu_pkg::op_lhb: begin
        src2_addr = instr[11:8];
        imm_ext   = {instr[7:0], 8'h00};
        reg_write = 1'b1;
      end
      cpu_pkg::op_pcs: reg_write = 1'b1;
      // B, BR, HLT and unused opcodes
      default: reg_write = 1'b0;
    endcase
  end

  // Condition table against current flags
  always_comb begin
    case (cond)
      cpu_pkg::cond_ne: cond_met = !flag_z;
      cpu_pkg::cond_eq: cond_met = flag_z;
      cpu_pkg::cond_gt: cond_met = !flag_z && !flag_n;
      cpu_pkg::cond_lt: cond_met = flag_n;
      cpu_pkg::cond_ge: cond_met = flag_z || (!flag_z && !flag_n);
      cpu_pkg::cond_le: cond_met = flag_n || flag_z;
      cpu_pkg::cond_ov: cond_met = flag_v;
      default:          cond_met = 1'b1;
    endcase
  end

  // Halfword offset, relative to next instruction
  assign br_offset = {{6{instr[8]}}, instr[8:0], 1'b0};

  assign branch_taken  = ((opcode == cpu_pkg::op_b) || (opcode == cpu_pkg::op_br)) && cond_met;
  assign branch_target = (opcode == cpu_pkg::op_br) ? rs_value : next_pc + br_offset;

endmodule

/* verilog/forwarding_unit.sv */
`timescale 1ns/10ps

module forwarding_unit (
  input  logic [cpu_pkg::reg_addr_width-1:0] ex_rs,
  input  logic [cpu_pkg::reg_addr_width-1:0] ex_src2,
  input  logic [cpu_pkg::reg_addr_width-1:0] mem_rd,
  input  logic                               mem_reg_write,
  input  logic [cpu_pkg::reg_addr_width-1:0] wb_rd,
  input  logic                               wb_reg_write,
  input  logic [cpu_pkg::reg_addr_width-1:0] mem_store_src,
  output cpu_pkg::fwd_sel_t                  fwd_a,
  output cpu_pkg::fwd_sel_t                  fwd_b,
  output logic                               fwd_store
);

  // Newest producer wins, R0 never forwarded
  function automatic cpu_pkg::fwd_sel_t pick_src(
    input logic [cpu_pkg::reg_addr_width-1:0] src
  );
    cpu_pkg::fwd_sel_t sel;
    sel = cpu_pkg::fwd_none;
    if (mem_reg_write && (mem_rd != '0) && (mem_rd == src)) begin
      sel = cpu_pkg::fwd_ex_mem;
    end else if (wb_reg_write && (wb_rd != '0) && (wb_rd == src)) begin
      sel = cpu_pkg::fwd_mem_wb;
    end
    return sel;
  endfunction

  assign fwd_a = pick_src(ex_rs);
  assign fwd_b = pick_src(ex_src2);

  // Store data from writeback when it matches
  assign fwd_store = wb_reg_write && (wb_rd != '0) && (wb_rd == mem_store_src);

endmodule

/* verilog/hazard_unit.sv */
`timescale 1ns/10ps

module hazard_unit (
  input  cpu_pkg::opcode_t                   id_opcode,
  input  logic [cpu_pkg::reg_addr_width-1:0] id_rs,
  input  logic [cpu_pkg::reg_addr_width-1:0] id_src2,
  input  logic                               ex_mem_read,
  input  logic                               ex_flag_write,
  input  logic                               ex_reg_write,
  input  logic [cpu_pkg::reg_addr_width-1:0] ex_rd,
  input  logic                               mem_reg_write,
  input  logic [cpu_pkg::reg_addr_width-1:0] mem_rd,
  input  logic                               branch_taken,
  output logic                               stall,
  output logic                               flush
);

  logic is_branch;
  logic load_use;
  logic flag_wait;
  logic rs_wait;

  assign is_branch = (id_opcode == cpu_pkg::op_b) || (id_opcode == cpu_pkg::op_br);

  // LW in execute feeding either decode source
  assign load_use = ex_mem_read && (ex_rd != '0) &&
                    ((ex_rd == id_rs) || (ex_rd == id_src2));

  // Flags not final until the setter leaves execute
  assign flag_wait = is_branch && ex_flag_write;

  // BR target register still in flight
  // MEM/WB case covered by register file bypass
  assign rs_wait = (id_opcode == cpu_pkg::op_br) && (id_rs != '0) &&
                   ((ex_reg_write && (ex_rd == id_rs)) ||
                    (mem_reg_write && (mem_rd == id_rs)));

  assign stall = load_use || flag_wait || rs_wait;

  // Redirect only once the branch is resolved
  assign flush = branch_taken && !stall;

  // Taken flag from decode only for B or BR
  flush_only_on_branch: assert final (!flush || is_branch)
    else $error("flush raised without a branch in decode");

endmodule

/* verilog/register_file.sv */
`timescale 1ns/10ps

module register_file (
  input  logic                               clk,
  input  logic                               arst_n,
  input  logic [cpu_pkg::reg_addr_width-1:0] rs_addr,
  input  logic [cpu_pkg::reg_addr_width-1:0] rt_addr,
  input  logic [cpu_pkg::reg_addr_width-1:0] wr_addr,
  input  logic                               wr_en,
  input  logic [cpu_pkg::data_width-1:0]     wr_data,
  output logic [cpu_pkg::data_width-1:0]     rs_data,
  output logic [cpu_pkg::data_width-1:0]     rt_data
);

  logic [cpu_pkg::data_width-1:0] regs [cpu_pkg::num_regs];

  // Write on rising edge, R0 never written
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < cpu_pkg::num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && (wr_addr != '0)) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // R0 reads zero
  // Same-cycle write is bypassed to the read ports
  assign rs_data = (rs_addr == '0) ? '0 :
                   (wr_en && (wr_addr == rs_addr)) ? wr_data : regs[rs_addr];
  assign rt_data = (rt_addr == '0) ? '0 :
                   (wr_en && (wr_addr == rt_addr)) ? wr_data : regs[rt_addr];

  // R0 stays zero across any write
  r0_stays_zero: assert property (@(posedge clk) disable iff (!arst_n)
    wr_en |=> (regs[0] == '0))
    else $error("R0 changed after a write");

endmodule
